// ==== common/xpu_macros.svh ====
//--------------------------------------------------------------------------
// constants for the xpu subset, clock rate fixed at 20 clocks per us
// register word addresses assume a 6-bit word address bus
//--------------------------------------------------------------------------
`ifndef XPU_MACROS_SVH
`define XPU_MACROS_SVH

`define XPU_NUM_CLK_PER_US 20 // main clock in MHz

// writable words
`define XPU_REG_TSF_LOAD_LO 2
`define XPU_REG_TSF_LOAD_HI 3 // bit 31 load trigger, 30:0 value bits 62:32
`define XPU_REG_MAC_LO 30
`define XPU_REG_MAC_HI 31 // address bits 47:32 in 15:0

// read only words
`define XPU_REG_TSF_RD_LO 58
`define XPU_REG_TSF_RD_HI 59
`define XPU_REG_ADDR2_RD 62
`define XPU_REG_HW_REV 63
`define XPU_HW_REV 32'hDEADBEEF

// byte offsets inside the 802.11 MAC header
`define XPU_HDR_FC_IDX 0
`define XPU_HDR_ADDR1_IDX 4
`define XPU_HDR_ADDR2_IDX 10

`endif

// ==== common/xpu_pkg.sv ====
//--------------------------------------------------------------------------
// shared types of the xpu subset
// all multi-byte fields are little-endian as received over the air
//--------------------------------------------------------------------------
`default_nettype none

package xpu_pkg;

  // TSF time in microseconds, 802.11 timer width
  typedef logic [63:0] tsf_t;

  // one 802.11 address, first received byte in bits 7:0
  typedef logic [47:0] mac_addr_t;

  // frame control in 15:0, duration in 31:16
  typedef logic [31:0] fc_di_t;

  // register word address and data
  typedef logic [5:0] reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // byte position inside the rx frame
  typedef logic [15:0] byte_idx_t;

endpackage

`default_nettype wire

// ==== common/mac_hdr_if.sv ====
//--------------------------------------------------------------------------
// parsed header fields, plain levels with no handshake
// each valid holds until the next header start or reset
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface mac_hdr_if import xpu_pkg::*; ();

  fc_di_t    fc_di;
  logic      fc_valid;
  mac_addr_t addr1;       // receiver address
  logic      addr1_valid;
  mac_addr_t addr2;       // transmitter address
  logic      addr2_valid;
  logic      pkt_for_me;  // only meaningful with addr1_valid

  modport parser (
    output fc_di, fc_valid,
    output addr1, addr1_valid,
    output addr2, addr2_valid,
    output pkt_for_me
  );

  modport monitor (
    input fc_di, fc_valid,
    input addr1, addr1_valid,
    input addr2, addr2_valid,
    input pkt_for_me
  );

endinterface

`default_nettype wire

// ==== tsf/tsf_timer.sv ====
//--------------------------------------------------------------------------
// 64-bit TSF counter with 1 us tick from a down-counting prescaler
// load_i is a single-cycle strobe, value visible in the next cycle
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "xpu_macros.svh"

module tsf_timer import xpu_pkg::*; (
  input  logic clk,
  input  logic rst_i,
  input  logic load_i,
  input  tsf_t load_val_i,
  output tsf_t tsf_o,
  output logic pulse_1m_o
);

  localparam int PRESC_W = $clog2(`XPU_NUM_CLK_PER_US);
  localparam logic [PRESC_W-1:0] PRESC_TOP = PRESC_W'(`XPU_NUM_CLK_PER_US - 1);

  logic [PRESC_W-1:0] presc_q; // clocks left in this us
  tsf_t               tsf_q;
  logic               pulse_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      presc_q <= PRESC_TOP;
      tsf_q   <= '0;
      pulse_q <= 1'b0;
    end else if (load_i) begin
      // restart the us period from the load
      presc_q <= PRESC_TOP;
      tsf_q   <= load_val_i;
      pulse_q <= 1'b0;
    end else if (presc_q == '0) begin
      presc_q <= PRESC_TOP;
      tsf_q   <= tsf_q + 1'b1; // step together with the pulse
      pulse_q <= 1'b1;
    end else begin
      presc_q <= presc_q - 1'b1;
      pulse_q <= 1'b0;
    end
  end

  assign tsf_o      = tsf_q;
  assign pulse_1m_o = pulse_q;

  // tick is a strobe, never a level
  a_pulse_single: assert property (
    @(posedge clk) disable iff (rst_i) pulse_1m_o |=> !pulse_1m_o
  );

endmodule

`default_nettype wire

// ==== rx_parse/hdr_field_capture.sv ====
//--------------------------------------------------------------------------
// collects a fixed byte range of the rx stream into one typed field
// field width must be a whole number of bytes, bytes arrive in order
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module hdr_field_capture import xpu_pkg::*; #(
  parameter type       field_t   = fc_di_t,
  parameter byte_idx_t START_IDX = '0
) (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       clear_i,
  input  logic [7:0] byte_i,
  input  byte_idx_t  byte_idx_i,
  input  logic       byte_valid_i,
  output field_t     field_o,
  output logic       field_valid_o
);

  localparam int NBYTES = $bits(field_t) / 8;
  localparam int LANE_W = (NBYTES > 1) ? $clog2(NBYTES) : 1;

  logic [NBYTES-1:0][7:0] lanes_q;
  logic                   valid_q;
  byte_idx_t              off;     // position inside the field
  logic                   in_range;
  logic                   last_byte;

  // below-range indices wrap to large offsets
  assign off       = byte_idx_i - START_IDX;
  assign in_range  = byte_valid_i && (off < byte_idx_t'(NBYTES));
  assign last_byte = in_range && (off == byte_idx_t'(NBYTES - 1));

  always_ff @(posedge clk) begin
    if (in_range) begin
      lanes_q[off[LANE_W-1:0]] <= byte_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i || clear_i) begin
      valid_q <= 1'b0;
    end else if (last_byte) begin
      valid_q <= 1'b1;
    end
  end

  assign field_o       = field_t'(lanes_q); // lane k -> bits 8k+7:8k
  assign field_valid_o = valid_q;

  a_field_stable: assert property (
    @(posedge clk) disable iff (rst_i) field_valid_o |=> !field_valid_o || $stable(field_o)
  );

endmodule

`default_nettype wire

// ==== rx_parse/phy_rx_parse.sv ====
//--------------------------------------------------------------------------
// rx MAC header parser for frame control/duration, address 1 and 2
// hdr_start_i clears every field valid, no other reset of the stream
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "xpu_macros.svh"

module phy_rx_parse import xpu_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       hdr_start_i,
  input  logic [7:0] byte_i,
  input  byte_idx_t  byte_idx_i,
  input  logic       byte_valid_i,
  input  mac_addr_t  self_mac_i,
  mac_hdr_if.parser  hdr
);

  localparam int MAC_BYTES = $bits(mac_addr_t) / 8;
  localparam byte_idx_t ADDR1_LAST = byte_idx_t'(`XPU_HDR_ADDR1_IDX + MAC_BYTES - 1);

  logic addr1_last; // final byte of address 1 on the bus
  logic pkt_for_me_q;

  hdr_field_capture #(
    .field_t   (fc_di_t),
    .START_IDX (byte_idx_t'(`XPU_HDR_FC_IDX))
  ) u_fc_cap (
    .clk           (clk),
    .rst_i         (rst_i),
    .clear_i       (hdr_start_i),
    .byte_i        (byte_i),
    .byte_idx_i    (byte_idx_i),
    .byte_valid_i  (byte_valid_i),
    .field_o       (hdr.fc_di),
    .field_valid_o (hdr.fc_valid)
  );

  hdr_field_capture #(
    .field_t   (mac_addr_t),
    .START_IDX (byte_idx_t'(`XPU_HDR_ADDR1_IDX))
  ) u_addr1_cap (
    .clk           (clk),
    .rst_i         (rst_i),
    .clear_i       (hdr_start_i),
    .byte_i        (byte_i),
    .byte_idx_i    (byte_idx_i),
    .byte_valid_i  (byte_valid_i),
    .field_o       (hdr.addr1),
    .field_valid_o (hdr.addr1_valid)
  );

  hdr_field_capture #(
    .field_t   (mac_addr_t),
    .START_IDX (byte_idx_t'(`XPU_HDR_ADDR2_IDX))
  ) u_addr2_cap (
    .clk           (clk),
    .rst_i         (rst_i),
    .clear_i       (hdr_start_i),
    .byte_i        (byte_i),
    .byte_idx_i    (byte_idx_i),
    .byte_valid_i  (byte_valid_i),
    .field_o       (hdr.addr2),
    .field_valid_o (hdr.addr2_valid)
  );

  assign addr1_last = byte_valid_i && (byte_idx_i == ADDR1_LAST);

  // compare with the top byte still on the bus, so the flag lands with addr1_valid
  always_ff @(posedge clk) begin
    if (rst_i || hdr_start_i) begin
      pkt_for_me_q <= 1'b0;
    end else if (addr1_last) begin
      pkt_for_me_q <= ({byte_i, hdr.addr1[39:0]} == self_mac_i);
    end
  end

  assign hdr.pkt_for_me = pkt_for_me_q;

endmodule

`default_nettype wire

// ==== source/xpu_regs.sv ====
//--------------------------------------------------------------------------
// register bank on a plain strobe port, one access per cycle
// readback is registered, unmapped reads give zero, unmapped writes drop
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "xpu_macros.svh"

module xpu_regs import xpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_i,
  input  logic      reg_wr_i,
  input  logic      reg_rd_i,
  input  reg_addr_t reg_addr_i,
  input  reg_data_t reg_wdata_i,
  output reg_data_t reg_rdata_o,
  input  tsf_t      tsf_i,
  mac_hdr_if.monitor hdr,
  output mac_addr_t self_mac_o,
  output logic      tsf_load_o,
  output tsf_t      tsf_load_val_o
);

  localparam reg_addr_t A_LOAD_LO = reg_addr_t'(`XPU_REG_TSF_LOAD_LO);
  localparam reg_addr_t A_LOAD_HI = reg_addr_t'(`XPU_REG_TSF_LOAD_HI);
  localparam reg_addr_t A_MAC_LO  = reg_addr_t'(`XPU_REG_MAC_LO);
  localparam reg_addr_t A_MAC_HI  = reg_addr_t'(`XPU_REG_MAC_HI);
  localparam reg_addr_t A_TSF_LO  = reg_addr_t'(`XPU_REG_TSF_RD_LO);
  localparam reg_addr_t A_TSF_HI  = reg_addr_t'(`XPU_REG_TSF_RD_HI);
  localparam reg_addr_t A_ADDR2   = reg_addr_t'(`XPU_REG_ADDR2_RD);
  localparam reg_addr_t A_HW_REV  = reg_addr_t'(`XPU_REG_HW_REV);

  reg_data_t   load_lo_q;
  reg_data_t   load_hi_q;
  reg_data_t   load_hi_nxt; // load word as it will be after this cycle
  reg_data_t   mac_lo_q;
  logic [15:0] mac_hi_q;
  reg_data_t   rd_word;
  reg_data_t   rdata_q;

  assign load_hi_nxt = (reg_wr_i && reg_addr_i == A_LOAD_HI) ? reg_wdata_i : load_hi_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      load_lo_q <= '0;
      load_hi_q <= '0;
      mac_lo_q  <= '0;
      mac_hi_q  <= '0;
    end else begin
      load_hi_q <= load_hi_nxt;
      if (reg_wr_i) begin
        case (reg_addr_i)
          A_LOAD_LO: load_lo_q <= reg_wdata_i;
          A_MAC_LO:  mac_lo_q  <= reg_wdata_i;
          A_MAC_HI:  mac_hi_q  <= reg_wdata_i[15:0];
          default:   ;
        endcase
      end
    end
  end

  // rising edge of the trigger bit, so the timer loads right after the write
  assign tsf_load_o     = load_hi_nxt[31] && !load_hi_q[31];
  assign tsf_load_val_o = {1'b0, load_hi_nxt[30:0], load_lo_q}; // bit 63 never loaded
  assign self_mac_o     = {mac_hi_q, mac_lo_q};

  always_comb begin
    case (reg_addr_i)
      A_LOAD_LO: rd_word = load_lo_q;
      A_LOAD_HI: rd_word = load_hi_q;
      A_MAC_LO:  rd_word = mac_lo_q;
      A_MAC_HI:  rd_word = {16'h0000, mac_hi_q};
      A_TSF_LO:  rd_word = tsf_i[31:0];
      A_TSF_HI:  rd_word = tsf_i[63:32];
      // byte-swapped upper four bytes of address 2
      A_ADDR2:   rd_word = {hdr.addr2[23:16], hdr.addr2[31:24],
                            hdr.addr2[39:32], hdr.addr2[47:40]};
      A_HW_REV:  rd_word = `XPU_HW_REV;
      default:   rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rdata_q <= '0;
    end else if (reg_rd_i) begin
      rdata_q <= rd_word; // held until the next read
    end
  end

  assign reg_rdata_o = rdata_q;

  a_no_wr_rd: assert property (
    @(posedge clk) disable iff (rst_i) !(reg_wr_i && reg_rd_i)
  );

endmodule

`default_nettype wire

// ==== source/xpu_top.sv ====
//--------------------------------------------------------------------------
// xpu subset top, single clock and one synchronous reset for all blocks
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module xpu_top import xpu_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,
  // register port
  input  logic       reg_wr_i,
  input  logic       reg_rd_i,
  input  reg_addr_t  reg_addr_i,
  input  reg_data_t  reg_wdata_i,
  output reg_data_t  reg_rdata_o,
  // demodulated byte stream
  input  logic       hdr_start_i,
  input  logic [7:0] byte_i,
  input  byte_idx_t  byte_idx_i,
  input  logic       byte_valid_i,
  // timer
  output tsf_t       tsf_o,
  output logic       tsf_pulse_1m_o,
  // station address and parsed header
  output mac_addr_t  mac_addr_o,
  output fc_di_t     fc_di_o,
  output logic       fc_valid_o,
  output mac_addr_t  addr1_o,
  output logic       addr1_valid_o,
  output mac_addr_t  addr2_o,
  output logic       addr2_valid_o,
  output logic       pkt_for_me_o
);

  logic tsf_load;
  tsf_t tsf_load_val;

  mac_hdr_if u_hdr ();

  xpu_regs u_regs (
    .clk            (clk),
    .rst_i          (rst_i),
    .reg_wr_i       (reg_wr_i),
    .reg_rd_i       (reg_rd_i),
    .reg_addr_i     (reg_addr_i),
    .reg_wdata_i    (reg_wdata_i),
    .reg_rdata_o    (reg_rdata_o),
    .tsf_i          (tsf_o),
    .hdr            (u_hdr.monitor),
    .self_mac_o     (mac_addr_o),
    .tsf_load_o     (tsf_load),
    .tsf_load_val_o (tsf_load_val)
  );

  tsf_timer u_tsf (
    .clk        (clk),
    .rst_i      (rst_i),
    .load_i     (tsf_load),
    .load_val_i (tsf_load_val),
    .tsf_o      (tsf_o),
    .pulse_1m_o (tsf_pulse_1m_o)
  );

  phy_rx_parse u_parse (
    .clk          (clk),
    .rst_i        (rst_i),
    .hdr_start_i  (hdr_start_i),
    .byte_i       (byte_i),
    .byte_idx_i   (byte_idx_i),
    .byte_valid_i (byte_valid_i),
    .self_mac_i   (mac_addr_o),
    .hdr          (u_hdr.parser)
  );

  // header fields straight out to the side channel
  assign fc_di_o       = u_hdr.fc_di;
  assign fc_valid_o    = u_hdr.fc_valid;
  assign addr1_o       = u_hdr.addr1;
  assign addr1_valid_o = u_hdr.addr1_valid;
  assign addr2_o       = u_hdr.addr2;
  assign addr2_valid_o = u_hdr.addr2_valid;
  assign pkt_for_me_o  = u_hdr.pkt_for_me;

endmodule

`default_nettype wire

// ==== bench/tb_xpu.sv ====
//--------------------------------------------------------------------------
// testbench for xpu_top, commands and expected values from bench/xpu_stimulus.txt
// run from the project root, each wait is bounded by its own cycle limit
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "xpu_macros.svh"

module tb_xpu import xpu_pkg::*; ();

  localparam int WAIT_LIMIT  = 64;                       // cycles for a header valid
  localparam int PULSE_LIMIT = 4 * `XPU_NUM_CLK_PER_US;

  logic       clk;
  logic       rst_i;
  logic       reg_wr_i;
  logic       reg_rd_i;
  reg_addr_t  reg_addr_i;
  reg_data_t  reg_wdata_i;
  reg_data_t  reg_rdata_o;
  logic       hdr_start_i;
  logic [7:0] byte_i;
  byte_idx_t  byte_idx_i;
  logic       byte_valid_i;
  tsf_t       tsf_o;
  logic       tsf_pulse_1m_o;
  mac_addr_t  mac_addr_o;
  fc_di_t     fc_di_o;
  logic       fc_valid_o;
  mac_addr_t  addr1_o;
  logic       addr1_valid_o;
  mac_addr_t  addr2_o;
  logic       addr2_valid_o;
  logic       pkt_for_me_o;

  logic [7:0] frame_bytes [0:63];
  int         errors;
  int         test_base; // error count when the current test began
  int         n_pass;
  int         n_fail;
  bit         file_bad;  // stimulus file missing or malformed

  xpu_top u_dut (
    .clk            (clk),
    .rst_i          (rst_i),
    .reg_wr_i       (reg_wr_i),
    .reg_rd_i       (reg_rd_i),
    .reg_addr_i     (reg_addr_i),
    .reg_wdata_i    (reg_wdata_i),
    .reg_rdata_o    (reg_rdata_o),
    .hdr_start_i    (hdr_start_i),
    .byte_i         (byte_i),
    .byte_idx_i     (byte_idx_i),
    .byte_valid_i   (byte_valid_i),
    .tsf_o          (tsf_o),
    .tsf_pulse_1m_o (tsf_pulse_1m_o),
    .mac_addr_o     (mac_addr_o),
    .fc_di_o        (fc_di_o),
    .fc_valid_o     (fc_valid_o),
    .addr1_o        (addr1_o),
    .addr1_valid_o  (addr1_valid_o),
    .addr2_o        (addr2_o),
    .addr2_valid_o  (addr2_valid_o),
    .pkt_for_me_o   (pkt_for_me_o)
  );

  always #2 clk = ~clk; // 4 ns period

  task automatic check_tsf(input tsf_t got, input tsf_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR @%0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_fc(input fc_di_t got, input fc_di_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR @%0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input mac_addr_t got, input mac_addr_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR @%0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("ERROR @%0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_reg(input reg_data_t got, input reg_data_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR @%0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("ERROR @%0t: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_failure(input string reason);
    $display("%s", reason);
    errors++;
  endtask

  task automatic read_hex(input int fd, output logic [63:0] v);
    int code;
    code = $fscanf(fd, "%h", v);
    if (code != 1) begin
      report_failure("stimulus file ends or breaks inside a command");
      file_bad = 1'b1;
    end
  endtask

  // all drivers below are entered on a falling edge and return on one
  task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
    reg_wr_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    @(negedge clk);
    reg_wr_i = 1'b0;
  endtask

  task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
    reg_rd_i   = 1'b1;
    reg_addr_i = addr;
    @(negedge clk);
    reg_rd_i = 1'b0;
    data     = reg_rdata_o;
  endtask

  task automatic strobe_hdr_start();
    hdr_start_i = 1'b1;
    @(negedge clk);
    hdr_start_i = 1'b0;
  endtask

  task automatic send_frame(input int len);
    int gap;
    strobe_hdr_start();
    for (int i = 0; i < len; i++) begin
      gap = $urandom % 4; // idle cycles before this byte
      repeat (gap) @(negedge clk);
      byte_valid_i = 1'b1;
      byte_i       = frame_bytes[i];
      byte_idx_i   = byte_idx_t'(i);
      @(negedge clk);
      byte_valid_i = 1'b0;
    end
  endtask

  function automatic logic flag_level(input int sel);
    case (sel)
      0:       return fc_valid_o;
      1:       return addr1_valid_o;
      default: return addr2_valid_o;
    endcase
  endfunction

  task automatic wait_valid(input int sel, input string name);
    int n;
    n = 0;
    while (!flag_level(sel) && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!flag_level(sel)) begin
      report_failure($sformatf("timeout: %s never went high", name));
    end
  endtask

  // cycles from the current falling edge to the one that shows the pulse
  task automatic wait_pulse(output int gap);
    gap = 0;
    do begin
      @(negedge clk);
      gap++;
    end while (!tsf_pulse_1m_o && gap < PULSE_LIMIT);
    if (!tsf_pulse_1m_o) begin
      report_failure("timeout: tsf_pulse_1m_o never arrived");
    end
  endtask

  task automatic tsf_load_run(input tsf_t val);
    tsf_t      expect_tsf;
    reg_data_t word;
    int        gap;
    // trigger low first so the final write is a rising edge
    reg_write(reg_addr_t'(`XPU_REG_TSF_LOAD_HI), {1'b0, val[62:32]});
    reg_write(reg_addr_t'(`XPU_REG_TSF_LOAD_LO), val[31:0]);
    reg_write(reg_addr_t'(`XPU_REG_TSF_LOAD_HI), {1'b1, val[62:32]});
    expect_tsf = {1'b0, val[62:0]};
    check_tsf(tsf_o, expect_tsf, "tsf_o after load");
    for (int i = 0; i < 3; i++) begin
      wait_pulse(gap);
      expect_tsf = expect_tsf + 64'd1;
      check_count(gap, `XPU_NUM_CLK_PER_US, "cycles between tsf pulses");
      check_tsf(tsf_o, expect_tsf, "tsf_o at pulse");
    end
    // both reads land well before the next pulse
    reg_read(reg_addr_t'(`XPU_REG_TSF_RD_LO), word);
    check_reg(word, expect_tsf[31:0], "TSF_RD_LO");
    reg_read(reg_addr_t'(`XPU_REG_TSF_RD_HI), word);
    check_reg(word, expect_tsf[63:32], "TSF_RD_HI");
  endtask

  initial begin
    int          fd;
    int          ch;
    string       cmd;
    string       name;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] n;
    logic [63:0] e_fc;
    logic [63:0] e_a1;
    logic [63:0] e_a2;
    logic [63:0] e_pkt;
    reg_data_t   word;

    clk          = 1'b0;
    rst_i        = 1'b1;
    reg_wr_i     = 1'b0;
    reg_rd_i     = 1'b0;
    reg_addr_i   = '0;
    reg_wdata_i  = '0;
    hdr_start_i  = 1'b0;
    byte_i       = '0;
    byte_idx_i   = '0;
    byte_valid_i = 1'b0;
    errors       = 0;
    test_base    = 0;
    n_pass       = 0;
    n_fail       = 0;
    file_bad     = 1'b0;
    void'($urandom(32'haa326965));

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    @(negedge clk);
    // first cycle out of reset
    check_bit(tsf_pulse_1m_o, 1'b0, "tsf_pulse_1m_o after reset");
    check_tsf(tsf_o, '0, "tsf_o after reset");
    check_bit(fc_valid_o, 1'b0, "fc_valid_o after reset");
    check_bit(addr1_valid_o, 1'b0, "addr1_valid_o after reset");
    check_bit(addr2_valid_o, 1'b0, "addr2_valid_o after reset");
    check_bit(pkt_for_me_o, 1'b0, "pkt_for_me_o after reset");

    fd = $fopen("bench/xpu_stimulus.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open bench/xpu_stimulus.txt");
      file_bad = 1'b1;
    end
    while (!file_bad && $fscanf(fd, "%s", cmd) == 1) begin
      if (cmd.substr(0, 0) == "#") begin
        ch = 0;
        while (ch != 10 && ch != -1) ch = $fgetc(fd); // skip the comment line
      end else if (cmd == "wr") begin
        read_hex(fd, a);
        read_hex(fd, b);
        reg_write(reg_addr_t'(a), reg_data_t'(b));
      end else if (cmd == "rd") begin
        read_hex(fd, a);
        read_hex(fd, b);
        reg_read(reg_addr_t'(a), word);
        check_reg(word, reg_data_t'(b), $sformatf("register %0d", a));
      end else if (cmd == "load") begin
        read_hex(fd, a);
        tsf_load_run(tsf_t'(a));
      end else if (cmd == "mac") begin
        read_hex(fd, a);
        check_addr(mac_addr_o, mac_addr_t'(a), "mac_addr_o");
      end else if (cmd == "frame") begin
        read_hex(fd, n);
        if (n > 64) begin
          report_failure("frame longer than 64 bytes in the stimulus file");
          file_bad = 1'b1;
        end else begin
          for (int i = 0; i < int'(n); i++) begin
            read_hex(fd, a);
            frame_bytes[i] = a[7:0];
          end
          read_hex(fd, e_fc);
          read_hex(fd, e_a1);
          read_hex(fd, e_a2);
          read_hex(fd, e_pkt);
          send_frame(int'(n));
          wait_valid(0, "fc_valid_o");
          wait_valid(1, "addr1_valid_o");
          wait_valid(2, "addr2_valid_o");
          check_fc(fc_di_o, fc_di_t'(e_fc), "fc_di_o");
          check_addr(addr1_o, mac_addr_t'(e_a1), "addr1_o");
          check_addr(addr2_o, mac_addr_t'(e_a2), "addr2_o");
          check_bit(pkt_for_me_o, e_pkt[0], "pkt_for_me_o");
        end
      end else if (cmd == "clear") begin
        strobe_hdr_start();
        check_bit(fc_valid_o, 1'b0, "fc_valid_o after hdr_start");
        check_bit(addr1_valid_o, 1'b0, "addr1_valid_o after hdr_start");
        check_bit(addr2_valid_o, 1'b0, "addr2_valid_o after hdr_start");
        check_bit(pkt_for_me_o, 1'b0, "pkt_for_me_o after hdr_start");
      end else if (cmd == "end") begin
        if ($fscanf(fd, "%s", name) != 1) begin
          report_failure("test end without a name");
          file_bad = 1'b1;
        end else if (errors == test_base) begin
          n_pass++;
          $display("%s: ok", name);
        end else begin
          n_fail++;
          $display("%s: %0d errors", name, errors - test_base);
        end
        test_base = errors;
      end else begin
        report_failure($sformatf("unknown command %s in the stimulus file", cmd));
        file_bad = 1'b1;
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    $display("tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, errors);
    if (n_fail == 0 && errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/xpu_stimulus.txt ====
# columns: command then hex fields. wr <addr> <data>, rd <addr> <expected word>,
# load <tsf value>, mac <expected mac_addr_o>, clear, end <test name>
# frame <byte count> <bytes> <expected fc_di> <addr1> <addr2> <pkt_for_me>
# revision word and an unmapped address straight after reset
rd 3f deadbeef
rd 05 00000000
end after_reset
# station 00:11:22:33:44:55, first byte on air in the lowest lane
wr 1e 33221100
wr 1f abcd5544
rd 1e 33221100
rd 1f 00005544
mac 554433221100
wr 05 12345678
rd 05 00000000
end reg_readback
# first load crosses the low word boundary during the pulses
load 00000012fffffffe
load 0000000000000005
load 7fffffff00001000
end tsf_load
# data frame addressed to the station
frame 10 08 02 3a 01 00 11 22 33 44 55 66 77 88 99 aa bb 013a0208 554433221100 bbaa99887766 1
rd 3e 8899aabb
end hdr_parse
# match, broadcast and a one-byte miss, each cleared by hdr_start
frame 10 08 02 3a 01 00 11 22 33 44 55 66 77 88 99 aa bb 013a0208 554433221100 bbaa99887766 1
clear
frame 10 80 00 00 00 ff ff ff ff ff ff 02 1a 2b 3c 4d 5e 00000080 ffffffffffff 5e4d3c2b1a02 0
rd 3e 2b3c4d5e
clear
frame 10 08 01 2c 00 00 11 22 33 44 54 66 77 88 99 aa bb 002c0108 544433221100 bbaa99887766 0
clear
end pkt_for_me

// ==== sources.f ====
+incdir+common
common/xpu_pkg.sv
common/mac_hdr_if.sv
tsf/tsf_timer.sv
rx_parse/hdr_field_capture.sv
rx_parse/phy_rx_parse.sv
source/xpu_regs.sv
source/xpu_top.sv
bench/tb_xpu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the xpu testbench with Verilator, runs it and checks the log
# run from anywhere, paths are taken relative to this script

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_xpu \
  -f sources.f \
  --Mdir "$BUILD_DIR" \
  -o tb_xpu
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_xpu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" "$LOG"; then
  echo "simulation reported failure, see $LOG"
  exit 1
fi

if ! grep -q "test passed" "$LOG"; then
  echo "no pass line found in $LOG"
  exit 1
fi

echo "simulation finished cleanly"
exit 0
